/* hw/mem_wb_pkg.sv */
package mem_wb_pkg;

    // one-hot load kind, all zero when not a load
    typedef logic [6:0] ld_op_t;

    localparam int LD_LB  = 0;
    localparam int LD_LBU = 1;
    localparam int LD_LH  = 2;
    localparam int LD_LHU = 3;
    localparam int LD_LW  = 4;
    localparam int LD_LWL = 5;
    localparam int LD_LWR = 6;

    // one-hot extension of the rotated load word
    typedef logic [4:0] extd_op_t;

    localparam int EXTD_SB = 0;
    localparam int EXTD_ZB = 1;
    localparam int EXTD_SH = 2;
    localparam int EXTD_ZH = 3;
    localparam int EXTD_W  = 4;

    typedef logic [7:0] exc_type_t;

    // data address error on load
    localparam int EXC_ADEL = 5;
    // instruction fetch address error, raised upstream
    localparam int EXC_ADEF = 6;

    typedef struct packed {
        logic        store_op;
        logic        bd;
        logic        exc;
        exc_type_t   exc_type;
        logic        eret;
        logic        cp0_wen;
        logic        res_from_cp0;
        logic [7:0]  cp0_addr;
        logic        res_from_mem;
        ld_op_t      ld_op;
        extd_op_t    extd_op;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] alu_result;
        logic [31:0] pc;
    } es_to_ms_t;

    typedef struct packed {
        logic [31:0] badvaddr;
        logic        bd;
        logic        exc;
        exc_type_t   exc_type;
        logic        eret;
        logic        cp0_wen;
        logic        res_from_cp0;
        logic [7:0]  cp0_addr;
        logic [3:0]  rf_be;
        logic [4:0]  dest;
        logic [31:0] result;
        logic [31:0] pc;
    } ms_to_ws_t;

    typedef struct packed {
        logic       busy;
        logic [3:0] rf_be;
        logic [4:0] dest;
    } stall_bus_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] value;
    } fwd_bus_t;

endpackage

/* hw/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_payload,
    input  logic     ready_go,
    input  logic     out_allowin,
    output logic     in_allowin,
    output logic     out_valid,
    output logic     valid,
    output payload_t payload
);

    assign in_allowin = !valid || (ready_go && out_allowin);
    assign out_valid  = valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (in_allowin) begin
            valid <= in_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            payload <= in_payload;
        end
    end

endmodule

/* hw/ld_decode.sv */
`timescale 1ns/1ps

module ld_decode import mem_wb_pkg::*; (
    input  ld_op_t     ld_op,
    input  logic [1:0] addr,
    input  logic       gr_we,
    output logic [3:0] rshift,
    output logic [3:0] rf_be,
    output logic       adel
);

    logic [1:0] amount;
    logic [3:0] be_raw;

    // lwl pulls the addressed byte up into byte 3
    always_comb begin
        if (ld_op[LD_LWL]) begin
            amount = addr + 2'd1;
        end else if (ld_op[LD_LW]) begin
            amount = 2'd0;
        end else begin
            amount = addr;
        end
    end

    assign rshift = 4'b0001 << amount;

    always_comb begin
        if (!gr_we) begin
            be_raw = 4'b0000;
        end else if (ld_op[LD_LWL]) begin
            case (addr)
                2'd0:    be_raw = 4'b1000;
                2'd1:    be_raw = 4'b1100;
                2'd2:    be_raw = 4'b1110;
                default: be_raw = 4'b1111;
            endcase
        end else if (ld_op[LD_LWR]) begin
            case (addr)
                2'd0:    be_raw = 4'b1111;
                2'd1:    be_raw = 4'b0111;
                2'd2:    be_raw = 4'b0011;
                default: be_raw = 4'b0001;
            endcase
        end else begin
            be_raw = 4'b1111;
        end
    end

    assign adel  = ((ld_op[LD_LH] || ld_op[LD_LHU]) && addr[0])
                || (ld_op[LD_LW] && (addr != 2'd0));
    assign rf_be = adel ? 4'b0000 : be_raw;

endmodule

/* hw/ld_select.sv */
`timescale 1ns/1ps

module ld_select import mem_wb_pkg::*; (
    input  logic [3:0]  rshift,
    input  extd_op_t    extd_op,
    input  logic [31:0] rdata,
    output logic [31:0] result
);

    logic [31:0] rotated;

    // rotate right by whole bytes
    always_comb begin
        case (rshift)
            4'b0010: rotated = {rdata[7:0],  rdata[31:8]};
            4'b0100: rotated = {rdata[15:0], rdata[31:16]};
            4'b1000: rotated = {rdata[23:0], rdata[31:24]};
            default: rotated = rdata;
        endcase
    end

    always_comb begin
        if (extd_op[EXTD_SB]) begin
            result = {{24{rotated[7]}}, rotated[7:0]};
        end else if (extd_op[EXTD_ZB]) begin
            result = {24'd0, rotated[7:0]};
        end else if (extd_op[EXTD_SH]) begin
            result = {{16{rotated[15]}}, rotated[15:0]};
        end else if (extd_op[EXTD_ZH]) begin
            result = {16'd0, rotated[15:0]};
        end else if (extd_op[EXTD_W]) begin
            // lwl and lwr merge through the byte enables
            result = rotated;
        end else begin
            result = 32'd0;
        end
    end

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import mem_wb_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        es_valid,
    input  es_to_ms_t   es_bus,
    input  logic        ws_allowin,
    input  logic        data_sram_data_ok,
    input  logic [31:0] data_sram_rdata,
    output logic        es_allowin,
    output logic        ms_valid_out,
    output ms_to_ws_t   ms_bus,
    output stall_bus_t  stall_bus,
    output fwd_bus_t    fwd_bus,
    output logic [1:0]  es_exc_eret
);

    logic        ms_valid;
    logic        ms_ready_go;
    es_to_ms_t   ms_in;

    logic        data_ok_r;
    logic [31:0] rdata_r;

    logic [3:0]  rshift;
    logic [3:0]  rf_be;
    logic        adel;
    logic [31:0] load_result;
    logic [31:0] result;

    always_ff @(posedge clk) begin
        if (reset) begin
            data_ok_r <= 1'b0;
        end else begin
            data_ok_r <= data_sram_data_ok;
        end
    end

    always_ff @(posedge clk) begin
        rdata_r <= data_sram_rdata;
    end

    // memory ops wait for the registered data_ok
    assign ms_ready_go = !((ms_in.res_from_mem || ms_in.store_op) && !data_ok_r);

    stage_reg #(
        .payload_t (es_to_ms_t)
    ) u_stage_reg (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (es_valid),
        .in_payload  (es_bus),
        .ready_go    (ms_ready_go),
        .out_allowin (ws_allowin),
        .in_allowin  (es_allowin),
        .out_valid   (ms_valid_out),
        .valid       (ms_valid),
        .payload     (ms_in)
    );

    ld_decode u_ld_decode (
        .ld_op  (ms_in.ld_op),
        .addr   (ms_in.alu_result[1:0]),
        .gr_we  (ms_in.gr_we),
        .rshift (rshift),
        .rf_be  (rf_be),
        .adel   (adel)
    );

    ld_select u_ld_select (
        .rshift  (rshift),
        .extd_op (ms_in.extd_op),
        .rdata   (rdata_r),
        .result  (load_result)
    );

    assign result = ms_in.res_from_mem ? load_result : ms_in.alu_result;

    always_comb begin
        ms_bus                   = '0;
        // fetch errors report the pc, data errors the address
        ms_bus.badvaddr          = ms_in.exc_type[EXC_ADEF] ? ms_in.pc : ms_in.alu_result;
        ms_bus.bd                = ms_in.bd;
        ms_bus.exc               = ms_in.exc || adel;
        ms_bus.exc_type          = ms_in.exc_type;
        ms_bus.exc_type[EXC_ADEL] = ms_in.exc_type[EXC_ADEL] || adel;
        ms_bus.eret              = ms_in.eret;
        ms_bus.cp0_wen           = ms_in.cp0_wen;
        ms_bus.res_from_cp0      = ms_in.res_from_cp0;
        ms_bus.cp0_addr          = ms_in.cp0_addr;
        ms_bus.rf_be             = rf_be;
        ms_bus.dest              = ms_in.dest;
        ms_bus.result            = result;
        ms_bus.pc                = ms_in.pc;
    end

    assign stall_bus.busy  = ms_valid && ms_in.gr_we;
    assign stall_bus.rf_be = {4{ms_valid}} & rf_be;
    assign stall_bus.dest  = ms_in.dest;

    // cp0 reads resolve later in wb
    assign fwd_bus.valid = ms_valid_out && !ms_in.res_from_cp0;
    assign fwd_bus.value = result;

    assign es_exc_eret = {2{ms_valid}} & {ms_bus.exc, ms_in.eret};

endmodule

/* hw/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage import mem_wb_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        ms_valid_in,
    input  ms_to_ws_t   ms_bus,
    output logic        ws_allowin,
    output logic        flush,
    output logic [3:0]  rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic        exc_valid,
    output exc_type_t   exc_type,
    output logic [31:0] exc_badvaddr,
    output logic [31:0] exc_epc,
    output logic        exc_bd
);

    logic      ws_valid;
    logic      rf_allowed;
    ms_to_ws_t ws_in;

    // always ready, each entry retires after one cycle
    stage_reg #(
        .payload_t (ms_to_ws_t)
    ) u_stage_reg (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (ms_valid_in),
        .in_payload  (ms_bus),
        .ready_go    (1'b1),
        .out_allowin (1'b1),
        .in_allowin  (ws_allowin),
        .out_valid   (ws_valid),
        .valid       (),
        .payload     (ws_in)
    );

    assign flush = ws_valid && (ws_in.exc || ws_in.eret);

    // no register write for exceptions, eret or mtc0
    assign rf_allowed = ws_valid && !ws_in.exc && !ws_in.eret && !ws_in.cp0_wen;
    assign rf_we      = rf_allowed ? ws_in.rf_be : 4'b0000;
    assign rf_waddr   = ws_in.dest;
    assign rf_wdata   = ws_in.result;

    assign exc_valid    = ws_valid && ws_in.exc;
    assign exc_type     = ws_in.exc_type;
    assign exc_badvaddr = ws_in.badvaddr;
    assign exc_epc      = ws_in.pc;
    assign exc_bd       = ws_in.bd;

endmodule

/* hw/mem_wb_top.sv */
`timescale 1ns/1ps

module mem_wb_top import mem_wb_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        es_valid,
    input  es_to_ms_t   es_bus,
    output logic        es_allowin,
    input  logic        data_sram_data_ok,
    input  logic [31:0] data_sram_rdata,
    output stall_bus_t  stall_bus,
    output fwd_bus_t    fwd_bus,
    output logic [1:0]  es_exc_eret,
    output logic [3:0]  rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic        exc_valid,
    output exc_type_t   exc_type,
    output logic [31:0] exc_badvaddr,
    output logic [31:0] exc_epc,
    output logic        exc_bd
);

    logic      flush;
    logic      ws_allowin;
    logic      ms_valid;
    ms_to_ws_t ms_bus;

    mem_stage u_mem_stage (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .es_valid          (es_valid),
        .es_bus            (es_bus),
        .ws_allowin        (ws_allowin),
        .data_sram_data_ok (data_sram_data_ok),
        .data_sram_rdata   (data_sram_rdata),
        .es_allowin        (es_allowin),
        .ms_valid_out      (ms_valid),
        .ms_bus            (ms_bus),
        .stall_bus         (stall_bus),
        .fwd_bus           (fwd_bus),
        .es_exc_eret       (es_exc_eret)
    );

    wb_stage u_wb_stage (
        .clk          (clk),
        .reset        (reset),
        .ms_valid_in  (ms_valid),
        .ms_bus       (ms_bus),
        .ws_allowin   (ws_allowin),
        .flush        (flush),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .exc_valid    (exc_valid),
        .exc_type     (exc_type),
        .exc_badvaddr (exc_badvaddr),
        .exc_epc      (exc_epc),
        .exc_bd       (exc_bd)
    );

endmodule

/* testbench/mem_wb_chk.sv */
`timescale 1ns/1ps

module mem_wb_chk import mem_wb_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      flush,
    input logic      es_allowin,
    input logic      ms_valid,
    input logic      ms_ready_go,
    input es_to_ms_t ms_in
);

    // mem comes out of reset empty
    assert property (@(posedge clk) reset |=> es_allowin)
        else $error("es_allowin low in the cycle after reset");

    // stalled entry keeps its payload
    assert property (@(posedge clk) disable iff (reset)
        ms_valid && !ms_ready_go |=> $stable(ms_in))
        else $error("mem payload changed while stalled");

    // flush empties mem and drops the excepting entry in wb
    assert property (@(posedge clk) disable iff (reset) flush |=> !ms_valid && !flush)
        else $error("a stage stayed valid after a flush");

endmodule

bind mem_stage mem_wb_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .es_allowin  (es_allowin),
    .ms_valid    (ms_valid),
    .ms_ready_go (ms_ready_go),
    .ms_in       (ms_in)
);

/* testbench/mem_wb_tb.sv */
`timescale 1ns/1ps

module mem_wb_tb import mem_wb_pkg::*; ();

    localparam int NREC  = 23;
    localparam int LIMIT = 40 * NREC + 50;

    logic        clk;
    logic        reset;
    logic        es_valid;
    es_to_ms_t   es_bus;
    logic        es_allowin;
    logic        data_sram_data_ok;
    logic [31:0] data_sram_rdata;
    stall_bus_t  stall_bus;
    fwd_bus_t    fwd_bus;
    logic [1:0]  es_exc_eret;
    logic [3:0]  rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic        exc_valid;
    exc_type_t   exc_type;
    logic [31:0] exc_badvaddr;
    logic [31:0] exc_epc;
    logic        exc_bd;

    // six words per record, see the data file
    logic [31:0] mw [0:NREC*6-1];
    int          exp_q[$];
    int          idx;
    int          ram_wait;
    int          cycles;
    int          mem_idx;
    logic        take;
    logic        in_mem;
    logic        flush_seen = 1'b0;
    logic [31:0] ram_word;
    logic [31:0] rng = 32'd42503;

    mem_wb_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            report_error("value mismatch");
        end
    endtask

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // delay slot flag, set on every other group of four records
    function automatic logic delay_slot(input int i);
        return i[2];
    endfunction

    function automatic es_to_ms_t record_bus(input int i);
        es_to_ms_t es;
        es              = '0;
        es.store_op     = mw[i*6][16];
        es.bd           = delay_slot(i);
        es.exc          = mw[i*6][20];
        es.exc_type     = mw[i*6][31:24];
        es.eret         = mw[i*6][19];
        es.res_from_mem = mw[i*6][17];
        es.ld_op        = mw[i*6][6:0];
        es.extd_op      = mw[i*6][12:8];
        es.gr_we        = mw[i*6][18];
        es.dest         = mw[i*6+1][4:0];
        es.alu_result   = mw[i*6+2];
        es.pc           = mw[i*6+3];
        return es;
    endfunction

    // mem holds record i in the cycle after it was accepted
    task automatic check_mem_buses(input int i);
        logic [31:0] ctrl;
        logic [3:0]  be;
        logic        mem_op;
        ctrl   = mw[i*6];
        mem_op = ctrl[16] || ctrl[17];
        // incoming exceptions keep the decoded enables
        be     = ctrl[20] ? {4{ctrl[18]}} : mw[i*6+1][11:8];
        check_value("stall_bus.busy", {31'd0, stall_bus.busy}, {31'd0, ctrl[18]});
        check_value("stall_bus.rf_be", {28'd0, stall_bus.rf_be}, {28'd0, be});
        check_value("stall_bus.dest", {27'd0, stall_bus.dest}, {27'd0, mw[i*6+1][4:0]});
        check_value("fwd_bus.valid", {31'd0, fwd_bus.valid}, {31'd0, !mem_op});
        if (!mem_op) begin
            check_value("fwd_bus.value", fwd_bus.value, mw[i*6+2]);
        end
        check_value("es_exc_eret", {30'd0, es_exc_eret}, {30'd0, ctrl[22], ctrl[19]});
    endtask

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d records issued", cycles, idx);
        $display("Test failed");
        $fatal(1, "simulation timed out");
    end

    // writeback holds each surviving record for one cycle, in order
    always @(negedge clk) begin
        int r;
        if (!reset) begin
            flush_seen = 1'b0;
            if (u_dut.u_wb_stage.ws_valid) begin
                if (exp_q.size() == 0) begin
                    report_error("writeback holds an instruction that should have been flushed");
                end
                r = exp_q.pop_front();
                // exceptions and eret clear both stages at the next edge
                flush_seen = mw[r*6][22] || mw[r*6][19];
                check_value("rf_we", {28'd0, rf_we}, {28'd0, mw[r*6+1][11:8]});
                if (mw[r*6+1][11:8] != 4'd0) begin
                    check_value("rf_waddr", {27'd0, rf_waddr}, {27'd0, mw[r*6+1][4:0]});
                    check_value("rf_wdata", rf_wdata, mw[r*6+5]);
                end
                check_value("exc_valid", {31'd0, exc_valid}, {31'd0, mw[r*6][22]});
                if (mw[r*6][22]) begin
                    check_value("exc_type", {24'd0, exc_type}, {24'd0, mw[r*6+1][31:24]});
                    check_value("exc_badvaddr", exc_badvaddr, mw[r*6+5]);
                    check_value("exc_epc", exc_epc, mw[r*6+3]);
                    check_value("exc_bd", {31'd0, exc_bd}, {31'd0, delay_slot(r)});
                end
            end else begin
                check_value("rf_we", {28'd0, rf_we}, 32'd0);
                check_value("exc_valid", {31'd0, exc_valid}, 32'd0);
            end
        end
    end

    initial begin
        reset             = 1'b1;
        es_valid          = 1'b0;
        es_bus            = '0;
        data_sram_data_ok = 1'b0;
        data_sram_rdata   = 32'd0;
        idx               = 0;
        mem_idx           = 0;
        in_mem            = 1'b0;
        ram_wait          = 0;
        ram_word          = 32'd0;
        $readmemh("testbench/mem_wb_input.txt", mw);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        while (idx < NREC || exp_q.size() > 0 || ram_wait > 0) begin
            data_sram_data_ok = 1'b0;
            if (ram_wait > 0) begin
                ram_wait = ram_wait - 1;
                if (ram_wait == 0) begin
                    data_sram_data_ok = 1'b1;
                    data_sram_rdata   = ram_word;
                end
            end
            es_valid = (idx < NREC);
            if (idx < NREC) begin
                es_bus = record_bus(idx);
            end
            @(negedge clk);
            if (in_mem) begin
                check_mem_buses(mem_idx);
            end
            if (ram_wait > 0 && es_allowin) begin
                report_error("es_allowin went high while a load was waiting for data_ok");
            end
            take = es_valid && es_allowin;
            @(posedge clk);
            // a record accepted on a flush edge never occupies mem
            in_mem = take && !flush_seen;
            if (take) begin
                mem_idx = idx;
                // killed records never reach the register file
                if (!mw[idx*6][21]) begin
                    exp_q.push_back(idx);
                end
                if (mw[idx*6][16] || mw[idx*6][17]) begin
                    ram_wait = int'(mw[idx*6+1][15:12]);
                    if (ram_wait == 0) begin
                        ram_wait = int'(next_random() % 32'd5) + 1;
                    end
                    ram_word = mw[idx*6+4];
                end
                idx++;
            end
            #1;
        end
        es_valid = 1'b0;
        $display("Test passed");
        $finish;
    end

endmodule

/* testbench/mem_wb_input.txt */
// ctrl{exc_type[31:24] exp_exc[22] killed[21] exc[20] eret[19] gr_we[18] mem[17] st[16] extd[12:8] ld[6:0]}
// info{exp_type[31:24] delay[15:12] rf_we[11:8] dest[4:0]}  alu_result  pc  ram_word  wdata_or_badvaddr
00040000 00000F01 12345678 BFC00000 00000000 12345678
00060101 00003F03 10000000 BFC00004 8594A3C2 FFFFFFC2
00060202 00000F04 10000001 BFC00008 8594A3C2 000000A3
00060101 00002F05 10000002 BFC0000C 8594A3C2 FFFFFF94
00060202 00000F06 10000003 BFC00010 8594A3C2 00000085
00060404 00001F07 10000004 BFC00014 8594A3C2 FFFFA3C2
00060808 00000F08 10000006 BFC00018 8594A3C2 00008594
00061010 00004F09 10000008 BFC0001C 8594A3C2 8594A3C2
00061020 0000080A 1000000C BFC00020 8594A3C2 C28594A3
00061020 00002E0B 1000000E BFC00024 8594A3C2 94A3C285
00061040 0000370C 10000011 BFC00028 8594A3C2 C28594A3
00010000 00002000 10000020 BFC0002C 00000000 00000000
00460404 2000200F 10000015 BFC00030 8594A3C2 10000015
00240000 00000F10 11111111 BFC00034 00000000 11111111
00240000 00000F11 22222222 BFC00038 00000000 22222222
00040000 00000F12 33333333 BFC0003C 00000000 33333333
40540000 40000013 44444444 BFC00041 00000000 BFC00041
00240000 00000F14 55555555 BFC00044 00000000 55555555
00240000 00000F15 66666666 BFC00048 00000000 66666666
00080000 00000016 00000000 BFC0004C 00000000 00000000
00240000 00000F17 77777777 BFC00050 00000000 77777777
00240000 00000F18 88888888 BFC00054 00000000 88888888
00040000 00000F19 99999999 BFC00058 00000000 99999999

/* mem_wb.f */
hw/mem_wb_pkg.sv
hw/stage_reg.sv
hw/ld_decode.sv
hw/ld_select.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/mem_wb_top.sv
testbench/mem_wb_chk.sv
testbench/mem_wb_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mem_wb testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mem_wb.f --top-module mem_wb_tb -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/Vmem_wb_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
exit 0
